// File: files.f
rtl/rv_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/rv_core_top.sv
tb/core_checker.sv
tb/tb_top.sv

// File: Makefile
# Verilator flow for the RV32 core testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# exit status comes from grep, so a missing pass line fails the target
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q -x "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam int n_alu = 12;
    localparam int n_dep = 12;
    localparam int n_rounds = 4;
    localparam int n_ctrl = 12;
    localparam int n_ill = 4;
    // every test also ends with one self-jump
    localparam int total_instr = n_alu + n_dep + n_rounds * 5 + 1 + n_ctrl + n_ill + 6;
    localparam int limit_cycles = total_instr * 8 + 300;

    logic     clk = 1'b0;
    logic     rst_n;
    addr_t    imem_addr;
    word_t    imem_data;
    addr_t    dmem_addr;
    byte_en_t dmem_rden;
    byte_en_t dmem_wren;
    word_t    dmem_wrdata;
    word_t    dmem_rddata;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     error;
    word_t    rom [0:63];
    word_t    ram [0:255];
    logic [31:0] rng = 32'd71868;
    int       pc_n;

    always #2 clk = ~clk;

    assign imem_data   = rom[imem_addr[7:2]];
    // disabled read lanes return the inverted word
    assign dmem_rddata = (dmem_rden == 4'hf) ? ram[dmem_addr[9:2]] : ~ram[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_wren == 4'hf) begin
            ram[dmem_addr[9:2]] <= dmem_wrdata;
        end
    end

    rv_core_top dut0 (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_rden(dmem_rden), .dmem_wren(dmem_wren),
        .dmem_wrdata(dmem_wrdata), .dmem_rddata(dmem_rddata), .wb_en(wb_en),
        .wb_rd(wb_rd), .wb_data(wb_data), .error(error)
    );

    core_checker chk0 (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .wb_en(wb_en), .wb_rd(wb_rd),
        .wb_data(wb_data), .dmem_rden(dmem_rden), .dmem_wren(dmem_wren),
        .dmem_addr(dmem_addr), .dmem_wrdata(dmem_wrdata), .error(error), .rom(rom),
        .ram(ram)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic reg_idx_t any_reg();
        return reg_idx_t'(1 + next_rand() % 31);
    endfunction

    function automatic word_t enc_i(logic [6:0] op, logic [2:0] f3, reg_idx_t rd,
                                    reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_r(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        return {7'b0, rs2, rs1, f3_add, rd, op_reg};
    endfunction

    function automatic word_t enc_s(reg_idx_t rs1, reg_idx_t rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3_word, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(reg_idx_t rs1, reg_idx_t rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3_bne, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic word_t enc_j(reg_idx_t rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    task automatic emit(input word_t w);
        rom[pc_n] = w;
        pc_n++;
    endtask

    // holds the core in reset while a new program is written
    task automatic clear_program();
        rst_n = 1'b0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = enc_i(op_imm, f3_add, 0, 0, 0);
        end
        for (int i = 0; i < 256; i++) begin
            ram[i] = (i * 32'h9e3779b1) ^ 32'h5a5a0000;
        end
        pc_n = 0;
    endtask

    task automatic run_test(input string name);
        emit(enc_j(0, 0));
        @(posedge clk);
        #0.5;
        chk0.start_test(name);
        chk0.check_quiet("in reset");
        @(posedge clk);
        #0.5;
        chk0.check_quiet("in reset");
        rst_n = 1'b1;
        @(posedge clk);
        #0.5;
        chk0.check_quiet("after reset");
        while (chk0.pending() > 0) begin
            @(posedge clk);
            #0.5;
        end
        // pipeline depth, catches late or extra retirements
        repeat (8) @(posedge clk);
        #0.5;
        chk0.finish_test();
    endtask

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, core stopped retiring", limit_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        reg_idx_t prev;
        reg_idx_t base;
        clear_program();
        run_test("reset_quiet");

        clear_program();
        for (int i = 0; i < n_alu; i++) begin
            case (next_rand() % 3)
                0: emit(enc_i(op_imm, f3_add, any_reg(), any_reg(), 12'(next_rand())));
                1: emit(enc_r(any_reg(), any_reg(), any_reg()));
                default: emit({20'(next_rand() >> 12), any_reg(), op_lui});
            endcase
        end
        run_test("alu_basic");

        clear_program();
        emit(enc_i(op_imm, f3_add, 1, 0, 12'(next_rand())));
        prev = 1;
        for (int i = 1; i < n_dep; i++) begin
            if (i % 2 == 1) begin
                emit(enc_r(prev + 5'd1, prev, prev));
            end else begin
                emit(enc_i(op_imm, f3_add, prev + 5'd1, prev, 12'(next_rand())));
            end
            prev = prev + 5'd1;
        end
        run_test("dependency_chain");

        clear_program();
        base = 5;
        for (int i = 0; i < n_rounds; i++) begin
            emit(enc_i(op_imm, f3_add, base, 0, 12'((next_rand() % 255) * 4)));
            emit(enc_i(op_imm, f3_add, 6, 0, 12'(next_rand())));
            emit(enc_s(base, 6, 0));
            emit(enc_i(op_load, f3_word, 7, base, 0));
            emit(enc_r(8, 7, 6));
        end
        // word next to the last store
        emit(enc_i(op_load, f3_word, 9, base, 4));
        run_test("load_store");

        clear_program();
        emit(enc_i(op_imm, f3_add, 1, 0, 1));
        emit(enc_i(op_imm, f3_add, 2, 0, 2));
        emit(enc_b(1, 2, 12));
        emit(enc_i(op_imm, f3_add, 3, 0, 99));
        emit(enc_i(op_imm, f3_add, 4, 0, 99));
        emit(enc_i(op_imm, f3_add, 5, 0, 5));
        emit(enc_b(1, 1, 8));
        emit(enc_i(op_imm, f3_add, 6, 0, 6));
        emit(enc_j(7, 12));
        emit(enc_i(op_imm, f3_add, 8, 0, 99));
        emit(enc_i(op_imm, f3_add, 9, 0, 99));
        emit(enc_i(op_imm, f3_add, 10, 7, 1));
        run_test("control_flow");

        clear_program();
        emit(enc_i(op_imm, f3_add, 1, 0, 12'(next_rand())));
        emit(enc_i(op_imm, f3_add, 2, 1, 3));
        emit(enc_r(3, 1, 2));
        emit(32'hffff_ffff);
        run_test("illegal_instruction");

        $display("tests run %0d, failed %0d", chk0.tests_run, chk0.tests_failed);
        if (chk0.tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb/core_checker.sv
module core_checker (
    input logic             clk,
    input logic             rst_n,
    input rv_pkg::addr_t    imem_addr,
    input logic             wb_en,
    input rv_pkg::reg_idx_t wb_rd,
    input rv_pkg::word_t    wb_data,
    input rv_pkg::byte_en_t dmem_rden,
    input rv_pkg::byte_en_t dmem_wren,
    input rv_pkg::addr_t    dmem_addr,
    input rv_pkg::word_t    dmem_wrdata,
    input logic             error,
    input rv_pkg::word_t    rom [0:63],
    input rv_pkg::word_t    ram [0:255]
);
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    logic [36:0] exp_wb[$];
    logic [63:0] exp_st[$];
    logic        exp_err;
    logic        active = 1'b0;
    string       cur_name;
    int          test_errs;
    int          tests_run = 0;
    int          tests_failed = 0;

    // instruction-set model, one instruction per step in program order
    function automatic void run_model();
        word_t    r [0:31];
        word_t    m [0:255];
        addr_t    pc;
        word_t    ins;
        word_t    a;
        word_t    b;
        word_t    val;
        word_t    imm_i;
        word_t    imm_b;
        word_t    imm_j;
        reg_idx_t rd;
        logic     wr;
        addr_t    next;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            m[i] = ram[i];
        end
        pc = '0;
        exp_err = 1'b0;
        for (int steps = 0; steps < 200; steps++) begin
            ins   = rom[pc[7:2]];
            rd    = ins[11:7];
            a     = r[ins[19:15]];
            b     = r[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            // self-jump closes the program
            if (ins[6:0] == op_jal && imm_j == '0) begin
                break;
            end
            next = pc + 4;
            wr   = 1'b0;
            val  = '0;
            if (ins[6:0] == op_imm && ins[14:12] == f3_add) begin
                val = a + imm_i;
                wr  = 1'b1;
            end else if (ins[6:0] == op_reg && ins[14:12] == f3_add && ins[31:25] == 0) begin
                val = a + b;
                wr  = 1'b1;
            end else if (ins[6:0] == op_lui) begin
                val = {ins[31:12], 12'b0};
                wr  = 1'b1;
            end else if (ins[6:0] == op_branch && ins[14:12] == f3_bne) begin
                if (a != b) begin
                    next = pc + imm_b;
                end
            end else if (ins[6:0] == op_jal) begin
                val  = pc + 4;
                wr   = 1'b1;
                next = pc + imm_j;
            end else if (ins[6:0] == op_load && ins[14:12] == f3_word) begin
                val = m[(a + imm_i) >> 2];
                wr  = 1'b1;
            end else if (ins[6:0] == op_store && ins[14:12] == f3_word) begin
                val = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                m[val[9:2]] = b;
                exp_st.push_back({val, b});
            end else begin
                exp_err = 1'b1;
            end
            if (wr && rd != 0) begin
                r[rd] = val;
                exp_wb.push_back({rd, val});
            end
            pc = next;
        end
    endfunction

    task automatic note_fail(input string msg);
        $display("%s: %s", cur_name, msg);
        test_errs++;
    endtask

    task automatic note_mismatch(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        $display("[ERROR] %s: %s expected %08h, actual %08h", cur_name, what, exp_v, act_v);
        test_errs++;
    endtask

    // reset leaves the core idle at address 0
    task automatic check_quiet(input string when);
        if (wb_en !== 1'b0) begin
            note_mismatch($sformatf("wb_en %s", when), '0, 32'(wb_en));
        end
        if (dmem_wren !== '0) begin
            note_mismatch($sformatf("dmem_wren %s", when), '0, 32'(dmem_wren));
        end
        if (dmem_rden !== '0) begin
            note_mismatch($sformatf("dmem_rden %s", when), '0, 32'(dmem_rden));
        end
        if (error !== 1'b0) begin
            note_mismatch($sformatf("error %s", when), '0, 32'(error));
        end
        if (imem_addr !== '0) begin
            note_mismatch($sformatf("imem_addr %s", when), '0, imem_addr);
        end
    endtask

    task automatic start_test(input string name);
        cur_name  = name;
        test_errs = 0;
        exp_wb.delete();
        exp_st.delete();
        run_model();
        active = 1'b1;
    endtask

    function automatic int pending();
        return exp_wb.size() + exp_st.size();
    endfunction

    task automatic finish_test();
        if (error !== exp_err) begin
            $display("[ERROR] %s: error flag expected %b, actual %b", cur_name, exp_err, error);
            test_errs++;
        end
        active = 1'b0;
        tests_run++;
        if (test_errs == 0) begin
            $display("PASS %s", cur_name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", cur_name, test_errs);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && active) begin
            if (wb_en) begin
                if (exp_wb.size() == 0) begin
                    note_fail($sformatf("unexpected register write to x%0d", wb_rd));
                end else if ({wb_rd, wb_data} !== exp_wb[0]) begin
                    $display("[ERROR] %s: write expected x%0d=%08h, actual x%0d=%08h",
                             cur_name, exp_wb[0][36:32], exp_wb[0][31:0], wb_rd, wb_data);
                    test_errs++;
                    void'(exp_wb.pop_front());
                end else begin
                    void'(exp_wb.pop_front());
                end
            end
            if (dmem_wren == 4'hf) begin
                if (exp_st.size() == 0) begin
                    note_fail($sformatf("unexpected store to %08h", dmem_addr));
                end else if ({dmem_addr, dmem_wrdata} !== exp_st[0]) begin
                    $display("[ERROR] %s: store expected [%08h]=%08h, actual [%08h]=%08h",
                             cur_name, exp_st[0][63:32], exp_st[0][31:0], dmem_addr,
                             dmem_wrdata);
                    test_errs++;
                    void'(exp_st.pop_front());
                end else begin
                    void'(exp_st.pop_front());
                end
            end
        end
    end

endmodule

// File: rtl/rv_core_top.sv
module rv_core_top (
    input  logic             clk,
    input  logic             rst_n,
    output rv_pkg::addr_t    imem_addr,
    input  rv_pkg::word_t    imem_data,
    output rv_pkg::addr_t    dmem_addr,
    output rv_pkg::byte_en_t dmem_rden,
    output rv_pkg::byte_en_t dmem_wren,
    output rv_pkg::word_t    dmem_wrdata,
    input  rv_pkg::word_t    dmem_rddata,
    output logic             wb_en,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    wb_data,
    output logic             error
);
    import rv_pkg::*;

    // fetch
    addr_t    f_pc;
    logic     f_valid;
    logic     stall;

    // decode and register file
    reg_idx_t rs1_idx, rs2_idx;
    word_t    rs1_data, rs2_data;
    inst_id_t d_inst_id;
    word_t    d_rs1_val, d_rs2_val, d_imm;
    addr_t    d_pc;
    reg_idx_t d_rd;

    // execute
    logic     jump_flag;
    addr_t    jump_addr;
    word_t    x_rd_val;
    logic     x_rd_vld;
    reg_idx_t x_rd;
    inst_id_t x_inst_id;
    addr_t    mem_addr;
    byte_en_t mem_rden, mem_wren;
    word_t    mem_wrdata;

    fetch_stage u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .jump_flag (jump_flag),
        .jump_addr (jump_addr),
        .imem_addr (imem_addr),
        .f_pc      (f_pc),
        .f_valid   (f_valid)
    );

    decode_stage u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_data (imem_data),
        .f_pc      (f_pc),
        .f_valid   (f_valid),
        .jump_flag (jump_flag),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .x_rd      (x_rd),
        .x_rd_vld  (x_rd_vld),
        .wb_rd     (wb_rd),
        .wb_en     (wb_en),
        .stall     (stall),
        .d_inst_id (d_inst_id),
        .d_rs1_val (d_rs1_val),
        .d_rs2_val (d_rs2_val),
        .d_imm     (d_imm),
        .d_pc      (d_pc),
        .d_rd      (d_rd)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .d_inst_id  (d_inst_id),
        .d_rs1_val  (d_rs1_val),
        .d_rs2_val  (d_rs2_val),
        .d_imm      (d_imm),
        .d_pc       (d_pc),
        .d_rd       (d_rd),
        .jump_flag  (jump_flag),
        .jump_addr  (jump_addr),
        .x_rd_val   (x_rd_val),
        .x_rd_vld   (x_rd_vld),
        .x_rd       (x_rd),
        .x_inst_id  (x_inst_id),
        .mem_addr   (mem_addr),
        .mem_rden   (mem_rden),
        .mem_wren   (mem_wren),
        .mem_wrdata (mem_wrdata),
        .error      (error)
    );

    mem_wb_stage u_mem_wb (
        .clk         (clk),
        .rst_n       (rst_n),
        .x_inst_id   (x_inst_id),
        .x_rd_val    (x_rd_val),
        .x_rd_vld    (x_rd_vld),
        .x_rd        (x_rd),
        .mem_addr    (mem_addr),
        .mem_rden    (mem_rden),
        .mem_wren    (mem_wren),
        .mem_wrdata  (mem_wrdata),
        .dmem_addr   (dmem_addr),
        .dmem_rden   (dmem_rden),
        .dmem_wren   (dmem_wren),
        .dmem_wrdata (dmem_wrdata),
        .dmem_rddata (dmem_rddata),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

endmodule

// File: rtl/mem_wb_stage.sv
module mem_wb_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::inst_id_t x_inst_id,
    input  rv_pkg::word_t    x_rd_val,
    input  logic             x_rd_vld,
    input  rv_pkg::reg_idx_t x_rd,
    input  rv_pkg::addr_t    mem_addr,
    input  rv_pkg::byte_en_t mem_rden,
    input  rv_pkg::byte_en_t mem_wren,
    input  rv_pkg::word_t    mem_wrdata,
    output rv_pkg::addr_t    dmem_addr,
    output rv_pkg::byte_en_t dmem_rden,
    output rv_pkg::byte_en_t dmem_wren,
    output rv_pkg::word_t    dmem_wrdata,
    input  rv_pkg::word_t    dmem_rddata,
    output logic             wb_en,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    wb_data
);
    import rv_pkg::*;

    logic  is_load;
    word_t wb_nxt;

    // request lives for the single cycle the execute register holds it
    assign dmem_addr   = mem_addr;
    assign dmem_rden   = mem_rden;
    assign dmem_wren   = mem_wren;
    assign dmem_wrdata = mem_wrdata;

    // full-word read lanes only for lw
    assign is_load = (x_inst_id == id_lw) && (mem_rden == '1);
    assign wb_nxt  = is_load ? dmem_rddata : x_rd_val;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= x_rd_vld;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= x_rd;
        wb_data <= wb_nxt;
    end

endmodule

// File: rtl/execute_stage.sv
module execute_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::inst_id_t d_inst_id,
    input  rv_pkg::word_t    d_rs1_val,
    input  rv_pkg::word_t    d_rs2_val,
    input  rv_pkg::word_t    d_imm,
    input  rv_pkg::addr_t    d_pc,
    input  rv_pkg::reg_idx_t d_rd,
    output logic             jump_flag,
    output rv_pkg::addr_t    jump_addr,
    output rv_pkg::word_t    x_rd_val,
    output logic             x_rd_vld,
    output rv_pkg::reg_idx_t x_rd,
    output rv_pkg::inst_id_t x_inst_id,
    output rv_pkg::addr_t    mem_addr,
    output rv_pkg::byte_en_t mem_rden,
    output rv_pkg::byte_en_t mem_wren,
    output rv_pkg::word_t    mem_wrdata,
    output logic             error
);
    import rv_pkg::*;

    word_t    alu_res;
    logic     take_jump;
    logic     writes_rd;
    byte_en_t rden_nxt;
    byte_en_t wren_nxt;

    always_comb begin
        alu_res   = '0;
        take_jump = 1'b0;
        writes_rd = 1'b0;
        rden_nxt  = '0;
        wren_nxt  = '0;
        case (d_inst_id)
            id_addi: begin
                alu_res   = d_rs1_val + d_imm;
                writes_rd = 1'b1;
            end
            id_add: begin
                alu_res   = d_rs1_val + d_rs2_val;
                writes_rd = 1'b1;
            end
            id_lui: begin
                alu_res   = d_imm;
                writes_rd = 1'b1;
            end
            id_bne: take_jump = (d_rs1_val != d_rs2_val);
            id_jal: begin
                // link value
                alu_res   = d_pc + word_t'(4);
                take_jump = 1'b1;
                writes_rd = 1'b1;
            end
            id_lw: begin
                writes_rd = 1'b1;
                rden_nxt  = '1;
            end
            id_sw:   wren_nxt = '1;
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jump_flag <= 1'b0;
            x_rd_vld  <= 1'b0;
            x_inst_id <= id_nop;
            mem_rden  <= '0;
            mem_wren  <= '0;
            error     <= 1'b0;
        end else begin
            jump_flag <= take_jump;
            // writes to x0 never reach writeback
            x_rd_vld  <= writes_rd && (d_rd != '0);
            x_inst_id <= d_inst_id;
            mem_rden  <= rden_nxt;
            mem_wren  <= wren_nxt;
            if (d_inst_id == id_illegal) begin
                error <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        x_rd_val   <= alu_res;
        x_rd       <= d_rd;
        jump_addr  <= d_pc + d_imm;
        mem_addr   <= d_rs1_val + d_imm;
        mem_wrdata <= d_rs2_val;
    end

endmodule

// File: rtl/reg_file.sv
module reg_file (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t rs1_idx,
    input  rv_pkg::reg_idx_t rs2_idx,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data,
    input  logic             wb_en,
    input  rv_pkg::reg_idx_t wb_rd,
    input  rv_pkg::word_t    wb_data
);
    import rv_pkg::*;

    word_t regs [31:1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // x0 reads zero, same-cycle write bypasses the array
    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_en && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_idx);
        rs2_data = read_port(rs2_idx);
    end

endmodule

// File: rtl/decode_stage.sv
module decode_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::word_t    imem_data,
    input  rv_pkg::addr_t    f_pc,
    input  logic             f_valid,
    input  logic             jump_flag,
    output rv_pkg::reg_idx_t rs1_idx,
    output rv_pkg::reg_idx_t rs2_idx,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    rs2_data,
    input  rv_pkg::reg_idx_t x_rd,
    input  logic             x_rd_vld,
    input  rv_pkg::reg_idx_t wb_rd,
    input  logic             wb_en,
    output logic             stall,
    output rv_pkg::inst_id_t d_inst_id,
    output rv_pkg::word_t    d_rs1_val,
    output rv_pkg::word_t    d_rs2_val,
    output rv_pkg::word_t    d_imm,
    output rv_pkg::addr_t    d_pc,
    output rv_pkg::reg_idx_t d_rd
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t      imm;
    inst_id_t   id_dec;
    inst_id_t   id_q;
    logic       use_rs1, use_rs2;
    logic       rs1_busy, rs2_busy;
    logic       d_writes_rd;

    assign opcode  = imem_data[6:0];
    assign rd      = imem_data[11:7];
    assign funct3  = imem_data[14:12];
    assign rs1_idx = imem_data[19:15];
    assign rs2_idx = imem_data[24:20];
    assign funct7  = imem_data[31:25];

    assign imm_i = {{20{imem_data[31]}}, imem_data[31:20]};
    assign imm_s = {{20{imem_data[31]}}, imem_data[31:25], imem_data[11:7]};
    assign imm_b = {{19{imem_data[31]}}, imem_data[31], imem_data[7],
                    imem_data[30:25], imem_data[11:8], 1'b0};
    assign imm_u = {imem_data[31:12], 12'b0};
    assign imm_j = {{11{imem_data[31]}}, imem_data[31], imem_data[19:12],
                    imem_data[20], imem_data[30:21], 1'b0};

    always_comb begin
        id_dec  = id_illegal;
        imm     = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            op_imm: if (funct3 == f3_add) begin
                id_dec  = id_addi;
                imm     = imm_i;
                use_rs1 = 1'b1;
            end
            op_reg: if (funct3 == f3_add && funct7 == 7'b0) begin
                id_dec  = id_add;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            op_lui: begin
                id_dec = id_lui;
                imm    = imm_u;
            end
            op_branch: if (funct3 == f3_bne) begin
                id_dec  = id_bne;
                imm     = imm_b;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            op_jal: begin
                id_dec = id_jal;
                imm    = imm_j;
            end
            op_load: if (funct3 == f3_word) begin
                id_dec  = id_lw;
                imm     = imm_i;
                use_rs1 = 1'b1;
            end
            op_store: if (funct3 == f3_word) begin
                id_dec  = id_sw;
                imm     = imm_s;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            default: id_dec = id_illegal;
        endcase
    end

    // pending destinations in decode output, execute and writeback
    assign d_writes_rd = (d_inst_id inside {id_addi, id_add, id_lui, id_jal, id_lw})
                         && (d_rd != '0);
    assign rs1_busy = (rs1_idx != '0) && ((d_writes_rd && d_rd == rs1_idx)
                      || (x_rd_vld && x_rd == rs1_idx) || (wb_en && wb_rd == rs1_idx));
    assign rs2_busy = (rs2_idx != '0) && ((d_writes_rd && d_rd == rs2_idx)
                      || (x_rd_vld && x_rd == rs2_idx) || (wb_en && wb_rd == rs2_idx));
    assign stall = f_valid && ((use_rs1 && rs1_busy) || (use_rs2 && rs2_busy));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_q <= id_nop;
        end else if (!f_valid || stall || jump_flag) begin
            id_q <= id_nop;
        end else begin
            id_q <= id_dec;
        end
    end

    always_ff @(posedge clk) begin
        d_rs1_val <= rs1_data;
        d_rs2_val <= rs2_data;
        d_imm     <= imm;
        d_pc      <= f_pc;
        d_rd      <= rd;
    end

    // older-path instruction still held here is killed by a taken transfer
    assign d_inst_id = jump_flag ? id_nop : id_q;

endmodule

// File: rtl/fetch_stage.sv
module fetch_stage (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          stall,
    input  logic          jump_flag,
    input  rv_pkg::addr_t jump_addr,
    output rv_pkg::addr_t imem_addr,
    output rv_pkg::addr_t f_pc,
    output logic          f_valid
);
    import rv_pkg::*;

    addr_t pc;
    logic  run;

    // first cycle after reset fetches address 0 but holds it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc  <= '0;
            run <= 1'b0;
        end else begin
            run <= 1'b1;
            if (jump_flag) begin
                pc <= jump_addr;
            end else if (run && !stall) begin
                pc <= pc + addr_t'(4);
            end
        end
    end

    assign imem_addr = pc;
    assign f_pc      = pc;

    // word on the bus during a redirect is a wrong-path fetch
    assign f_valid = run && !jump_flag;

endmodule

// File: rtl/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [xlen-1:0] addr_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [3:0]      byte_en_t;

    // major opcodes, bits [6:0]
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;

    // funct3, bits [14:12]
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_word = 3'b010;

    // decoded identity, id_nop is a bubble
    typedef enum logic [3:0] {
        id_addi,
        id_add,
        id_lui,
        id_bne,
        id_jal,
        id_lw,
        id_sw,
        id_illegal,
        id_nop
    } inst_id_t;

endpackage
